// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f vlog.f -o core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1

// File: src/core_pkg.sv
package core_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Base opcodes of the supported subset.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  // Same encoding as funct3[1:0].
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_width_t;

  typedef enum logic {
    WB_ALU,
    WB_MEM
  } wb_sel_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic            valid;
  } if_id_t;

  typedef struct packed {
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] store_data; // Raw rs2 value.
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            use_rs1;
    logic            use_rs2;
    alu_op_t         alu_op;
    logic [4:0]      rd;
    logic            reg_write;
    logic            mem_write;
    logic            mem_read;
    mem_width_t      mem_width;
    logic            mem_sign;
    wb_sel_t         wb_sel;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] store_data;
    logic [4:0]      rd;
    logic            reg_write;
    logic            mem_write;
    logic            mem_read;
    mem_width_t      mem_width;
    logic            mem_sign;
    wb_sel_t         wb_sel;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic [4:0]      rd;
    logic            reg_write;
  } mem_wb_t;

  // All enables and valid flags clear.
  localparam if_id_t  IF_ID_BUBBLE  = '0;
  localparam id_ex_t  ID_EX_BUBBLE  = '0;
  localparam ex_mem_t EX_MEM_BUBBLE = '0;
  localparam mem_wb_t MEM_WB_BUBBLE = '0;

endpackage

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import core_pkg::*;
(
  input  logic    clk,
  input  if_id_t  if_id_i,
  input  id_ex_t  id_ex_q_i,
  input  mem_wb_t wb_i,
  output id_ex_t  id_ex_o,
  output logic    load_use_o
);

  logic [31:0]     instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct7_5;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] rd1;
  logic [XLEN-1:0] rd2;

  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sub,
                                         input logic sra);
    case (f3)
      3'b000:  alu_decode = sub ? ALU_SUB : ALU_ADD;
      3'b001:  alu_decode = ALU_SLL;
      3'b010:  alu_decode = ALU_SLT;
      3'b011:  alu_decode = ALU_SLTU;
      3'b100:  alu_decode = ALU_XOR;
      3'b101:  alu_decode = sra ? ALU_SRA : ALU_SRL;
      3'b110:  alu_decode = ALU_OR;
      default: alu_decode = ALU_AND;
    endcase
  endfunction

  assign instr    = if_id_i.instr;
  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign funct7_5 = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  reg_file reg_file_i (
    .clk   (clk),
    .rs1_i (rs1),
    .rs2_i (rs2),
    .rd1_o (rd1),
    .rd2_o (rd2),
    .wb_i  (wb_i)
  );

  always_comb begin
    id_ex_o            = ID_EX_BUBBLE;
    id_ex_o.rs1        = rs1;
    id_ex_o.rs2        = rs2;
    id_ex_o.rd         = rd;
    id_ex_o.store_data = rd2;
    id_ex_o.op_a       = rd1;
    case (opcode)
      OPC_OP: begin
        id_ex_o.op_b      = rd2;
        id_ex_o.use_rs1   = 1'b1;
        id_ex_o.use_rs2   = 1'b1;
        id_ex_o.alu_op    = alu_decode(funct3, funct7_5, funct7_5);
        id_ex_o.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        id_ex_o.op_b      = imm_i;
        id_ex_o.use_rs1   = 1'b1;
        id_ex_o.alu_op    = alu_decode(funct3, 1'b0, funct7_5); // No SUBI.
        id_ex_o.reg_write = 1'b1;
      end
      OPC_LUI: begin
        id_ex_o.op_a      = '0;
        id_ex_o.op_b      = imm_u;
        id_ex_o.alu_op    = ALU_PASS_B;
        id_ex_o.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        id_ex_o.op_a      = if_id_i.pc;
        id_ex_o.op_b      = imm_u;
        id_ex_o.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        id_ex_o.op_b      = imm_i;
        id_ex_o.use_rs1   = 1'b1;
        id_ex_o.reg_write = 1'b1;
        id_ex_o.mem_read  = 1'b1;
        id_ex_o.mem_width = mem_width_t'(funct3[1:0]);
        id_ex_o.mem_sign  = ~funct3[2];
        id_ex_o.wb_sel    = WB_MEM;
      end
      OPC_STORE: begin
        id_ex_o.op_b      = imm_s;
        id_ex_o.use_rs1   = 1'b1;
        id_ex_o.use_rs2   = 1'b1; // Store data only.
        id_ex_o.mem_write = 1'b1;
        id_ex_o.mem_width = mem_width_t'(funct3[1:0]);
      end
      default: ;
    endcase
    if (rd == 5'd0) id_ex_o.reg_write = 1'b0;
    if (!if_id_i.valid) id_ex_o = ID_EX_BUBBLE;
  end

  // Load result is not ready for execute next cycle.
  assign load_use_o = id_ex_q_i.mem_read && id_ex_q_i.rd != 5'd0 &&
                      ((id_ex_o.use_rs1 && rs1 == id_ex_q_i.rd) ||
                       (id_ex_o.use_rs2 && rs2 == id_ex_q_i.rd));

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import core_pkg::*;
(
  input  id_ex_t  id_ex_i,
  input  ex_mem_t ex_mem_q_i,
  input  mem_wb_t mem_wb_q_i,
  output ex_mem_t ex_mem_o
);

  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] rs2_val;
  logic [4:0]      shamt;
  logic [XLEN-1:0] result;

  // Newest producer wins. A load in EX/MEM never matches here.
  function automatic logic [XLEN-1:0] fwd(input logic [4:0] rs, input logic [XLEN-1:0] stale,
                                          input ex_mem_t em, input mem_wb_t mw);
    if (rs == 5'd0) fwd = stale;
    else if (em.reg_write && em.wb_sel == WB_ALU && em.rd == rs) fwd = em.result;
    else if (mw.reg_write && mw.rd == rs) fwd = mw.data;
    else fwd = stale;
  endfunction

  always_comb begin
    src_a   = id_ex_i.op_a;
    rs2_val = id_ex_i.store_data;
    if (id_ex_i.use_rs1) src_a = fwd(id_ex_i.rs1, id_ex_i.op_a, ex_mem_q_i, mem_wb_q_i);
    if (id_ex_i.use_rs2) begin
      rs2_val = fwd(id_ex_i.rs2, id_ex_i.store_data, ex_mem_q_i, mem_wb_q_i);
    end
    src_b = (id_ex_i.use_rs2 && !id_ex_i.mem_write) ? rs2_val : id_ex_i.op_b; // Stores add imm.
  end

  assign shamt = src_b[4:0];

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_SUB:    result = src_a - src_b;
      ALU_AND:    result = src_a & src_b;
      ALU_OR:     result = src_a | src_b;
      ALU_XOR:    result = src_a ^ src_b;
      ALU_SLT:    result = XLEN'($signed(src_a) < $signed(src_b));
      ALU_SLTU:   result = XLEN'(src_a < src_b);
      ALU_SLL:    result = src_a << shamt;
      ALU_SRL:    result = src_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(src_a) >>> shamt);
      ALU_PASS_B: result = src_b;
      default:    result = src_a + src_b;
    endcase
  end

  always_comb begin
    ex_mem_o.result     = result;
    ex_mem_o.store_data = rs2_val;
    ex_mem_o.rd         = id_ex_i.rd;
    ex_mem_o.reg_write  = id_ex_i.reg_write;
    ex_mem_o.mem_write  = id_ex_i.mem_write;
    ex_mem_o.mem_read   = id_ex_i.mem_read;
    ex_mem_o.mem_width  = id_ex_i.mem_width;
    ex_mem_o.mem_sign   = id_ex_i.mem_sign;
    ex_mem_o.wb_sel     = id_ex_i.wb_sel;
  end

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  input  logic            hold_i,
  input  logic [31:0]     imem_data_i,
  output logic [XLEN-1:0] imem_addr_o,
  output if_id_t          if_id_o
);

  logic [XLEN-1:0] pc_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else if (!hold_i) begin
      pc_q <= pc_q + XLEN'(4); // No branches, so always sequential.
    end
  end

  assign imem_addr_o = pc_q;

  // Instruction memory answers in the same cycle.
  always_comb begin
    if_id_o.pc    = pc_q;
    if_id_o.instr = imem_data_i;
    if_id_o.valid = 1'b1;
  end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
  import core_pkg::*;
(
  input  ex_mem_t         ex_mem_i,
  input  logic [XLEN-1:0] dmem_rdata_i,
  output logic [XLEN-1:0] dmem_addr_o,
  output logic [XLEN-1:0] dmem_wdata_o,
  output logic [3:0]      dmem_wstrb_o,
  output logic            dmem_we_o,
  output mem_wb_t         mem_wb_o
);

  logic [1:0]      offset;
  logic [XLEN-1:0] lane;
  logic [XLEN-1:0] load_val;

  assign offset      = ex_mem_i.result[1:0];
  assign dmem_addr_o = {ex_mem_i.result[XLEN-1:2], 2'b00};
  assign dmem_we_o   = ex_mem_i.mem_write;

  // Data goes on every lane, strobes pick the target.
  always_comb begin
    case (ex_mem_i.mem_width)
      MEM_BYTE: dmem_wdata_o = {4{ex_mem_i.store_data[7:0]}};
      MEM_HALF: dmem_wdata_o = {2{ex_mem_i.store_data[15:0]}};
      default:  dmem_wdata_o = ex_mem_i.store_data;
    endcase
    case (ex_mem_i.mem_width)
      MEM_BYTE: dmem_wstrb_o = 4'b0001 << offset;
      MEM_HALF: dmem_wstrb_o = offset[1] ? 4'b1100 : 4'b0011;
      default:  dmem_wstrb_o = 4'b1111;
    endcase
    if (!ex_mem_i.mem_write) dmem_wstrb_o = 4'b0000;
  end

  assign lane = dmem_rdata_i >> {offset, 3'b000};

  always_comb begin
    case (ex_mem_i.mem_width)
      MEM_BYTE: load_val = {{24{ex_mem_i.mem_sign & lane[7]}}, lane[7:0]};
      MEM_HALF: load_val = {{16{ex_mem_i.mem_sign & lane[15]}}, lane[15:0]};
      default:  load_val = dmem_rdata_i;
    endcase
    mem_wb_o.data      = (ex_mem_i.wb_sel == WB_MEM) ? load_val : ex_mem_i.result;
    mem_wb_o.rd        = ex_mem_i.rd;
    mem_wb_o.reg_write = ex_mem_i.reg_write;
  end

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type      payload_t = logic,
  parameter payload_t BUBBLE    = '0
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     hold_i,
  input  logic     bubble_i,
  input  payload_t d_i,
  output payload_t q_o
);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      q_o <= BUBBLE;
    end else if (!hold_i) begin
      q_o <= bubble_i ? BUBBLE : d_i; // Hold wins over bubble.
    end
  end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import core_pkg::*;
(
  input  logic            clk,
  input  logic [4:0]      rs1_i,
  input  logic [4:0]      rs2_i,
  output logic [XLEN-1:0] rd1_o,
  output logic [XLEN-1:0] rd2_o,
  input  mem_wb_t         wb_i
);

  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (wb_i.reg_write && wb_i.rd != 5'd0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // x0 reads zero, a write in flight is passed through.
  always_comb begin
    if (rs1_i == 5'd0) rd1_o = '0;
    else if (wb_i.reg_write && wb_i.rd == rs1_i) rd1_o = wb_i.data;
    else rd1_o = regs[rs1_i];

    if (rs2_i == 5'd0) rd2_o = '0;
    else if (wb_i.reg_write && wb_i.rd == rs2_i) rd2_o = wb_i.data;
    else rd2_o = regs[rs2_i];
  end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            reset_i,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic [31:0]     imem_data_i,
  output logic [XLEN-1:0] dmem_addr_o,
  output logic [XLEN-1:0] dmem_wdata_o,
  output logic [3:0]      dmem_wstrb_o,
  output logic            dmem_we_o,
  input  logic [XLEN-1:0] dmem_rdata_i,
  input  logic            dmem_stall_i,
  output logic            wb_valid_o,
  output logic [4:0]      wb_addr_o,
  output logic [XLEN-1:0] wb_data_o
);

  if_id_t  if_id_d, if_id_q;
  id_ex_t  id_ex_d, id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  mem_wb_t mem_wb_d, mem_wb_q;
  mem_wb_t wb_commit;
  logic    load_use;
  logic    front_hold;

  assign front_hold = dmem_stall_i | load_use;

  // MEM/WB holds through a stall, commit once on the release cycle.
  always_comb begin
    wb_commit           = mem_wb_q;
    wb_commit.reg_write = mem_wb_q.reg_write & ~dmem_stall_i;
  end

  assign wb_valid_o = wb_commit.reg_write;
  assign wb_addr_o  = wb_commit.rd;
  assign wb_data_o  = wb_commit.data;

  fetch_stage fetch_stage_i (
    .clk, .reset_i, .hold_i(front_hold), .imem_data_i, .imem_addr_o, .if_id_o(if_id_d)
  );

  pipe_reg #(.payload_t(if_id_t), .BUBBLE(IF_ID_BUBBLE)) if_id_reg (
    .clk, .reset_i, .hold_i(front_hold), .bubble_i(1'b0), .d_i(if_id_d), .q_o(if_id_q)
  );

  decode_stage decode_stage_i (
    .clk, .if_id_i(if_id_q), .id_ex_q_i(id_ex_q), .wb_i(wb_commit),
    .id_ex_o(id_ex_d), .load_use_o(load_use)
  );

  pipe_reg #(.payload_t(id_ex_t), .BUBBLE(ID_EX_BUBBLE)) id_ex_reg (
    .clk, .reset_i, .hold_i(dmem_stall_i), .bubble_i(load_use), .d_i(id_ex_d), .q_o(id_ex_q)
  );

  execute_stage execute_stage_i (
    .id_ex_i(id_ex_q), .ex_mem_q_i(ex_mem_q), .mem_wb_q_i(mem_wb_q), .ex_mem_o(ex_mem_d)
  );

  pipe_reg #(.payload_t(ex_mem_t), .BUBBLE(EX_MEM_BUBBLE)) ex_mem_reg (
    .clk, .reset_i, .hold_i(dmem_stall_i), .bubble_i(1'b0), .d_i(ex_mem_d), .q_o(ex_mem_q)
  );

  mem_stage mem_stage_i (
    .ex_mem_i(ex_mem_q), .dmem_rdata_i, .dmem_addr_o, .dmem_wdata_o, .dmem_wstrb_o,
    .dmem_we_o, .mem_wb_o(mem_wb_d)
  );

  pipe_reg #(.payload_t(mem_wb_t), .BUBBLE(MEM_WB_BUBBLE)) mem_wb_reg (
    .clk, .reset_i, .hold_i(dmem_stall_i), .bubble_i(1'b0), .d_i(mem_wb_d), .q_o(mem_wb_q)
  );

endmodule

// File: testbench/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

typedef struct packed {
  logic [4:0]  rd;
  logic [31:0] data;
} retire_t;

typedef struct packed {
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;
} store_t;

logic [31:0] lfsr_q = 32'ha2fd;
logic [31:0] prog [ROM_WORDS];
logic [31:0] mem [RAM_WORDS]; // Model copy of the data RAM.
retire_t     exp_ret [$];
store_t      exp_st [$];

// Galois LFSR, one step per bit taken.
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_q[0]};
    lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'ha300_0000 : 32'h0);
  end
  return v;
endfunction

function automatic logic [31:0] fill_word(input int i);
  return (32'h9e37_79b9 * (i + 1)) ^ {i[7:0], 24'h00_0000};
endfunction

// Register and immediate ALU forms, LUI and AUIPC on x0 to x7.
function automatic logic [31:0] gen_alu();
  logic [31:0] r;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic        alt;
  r   = rand_bits(32);
  rd  = {2'b00, r[2:0]};
  rs1 = {2'b00, r[5:3]};
  rs2 = {2'b00, r[8:6]};
  f3  = r[11:9];
  alt = r[12] && (f3 == 3'd0 || f3 == 3'd5);
  case (r[14:13])
    2'd0: return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, OPC_OP};
    2'd1: begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        return {1'b0, alt, 5'd0, r[19:15], rs1, f3, rd, OPC_OP_IMM}; // Shift by immediate.
      end
      return {r[26:15], rs1, f3, rd, OPC_OP_IMM};
    end
    2'd2: return {r[31:12], rd, OPC_LUI};
    default: return {r[31:12], rd, OPC_AUIPC};
  endcase
endfunction

// Load or store relative to x0, aligned to its width.
function automatic logic [31:0] gen_mem(input logic is_load);
  logic [31:0] r;
  logic [2:0]  f3;
  logic [11:0] off;
  r   = rand_bits(14);
  f3  = {1'b0, (r[1:0] == 2'd3) ? 2'd2 : r[1:0]};
  off = {4'd0, r[10:5], 2'b00};
  if (f3[1:0] == 2'd0) off[1:0] = r[12:11];
  if (f3[1:0] == 2'd1) off[1] = r[11];
  if (!is_load) return {off[11:5], 2'b00, r[4:2], 5'd0, f3, off[4:0], OPC_STORE};
  if (f3[1:0] != 2'd2) f3[2] = r[13]; // LBU and LHU.
  return {off, 5'd0, f3, 2'b00, r[4:2], OPC_LOAD};
endfunction

// Consumer of src right after a load.
function automatic logic [31:0] gen_use(input logic [4:0] src);
  logic [31:0] r;
  logic [31:0] w;
  r = rand_bits(10);
  if (r[9]) begin
    w = gen_mem(1'b0);
    w[24:20] = src; // Stores the loaded value.
    return w;
  end
  return {7'd0, 2'b00, r[2:0], src, r[5:3], 2'b00, r[8:6], OPC_OP};
endfunction

task automatic build_program(input int kind);
  logic [31:0] r;
  for (int i = 0; i < ROM_WORDS; i++) begin
    r = rand_bits(12);
    if (i < 7) begin
      prog[i] = {r[11:0], 5'd0, 3'd0, 5'(i + 1), OPC_OP_IMM}; // Seeds x1 to x7.
    end else begin
      case (kind)
        KIND_ALU:      prog[i] = gen_alu();
        KIND_MEM:      prog[i] = gen_mem(r[0]);
        KIND_LOAD_USE: prog[i] = (i % 2 == 1) ? gen_mem(1'b1) : gen_use(prog[i - 1][11:7]);
        default: begin
          if (r[1:0] == 2'd0) prog[i] = gen_mem(1'b1);
          else if (r[1:0] == 2'd1) prog[i] = gen_mem(1'b0);
          else prog[i] = gen_alu();
        end
      endcase
    end
  end
endtask

function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'd0, $signed(a) < $signed(b)};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// Runs the program in order and lists the retirements and stores it must produce.
task automatic run_model();
  logic [31:0] x [32];
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] addr;
  logic [31:0] val;
  logic [31:0] word;
  logic [3:0]  strb;
  retire_t     ret;
  store_t      st;
  exp_ret.delete();
  exp_st.delete();
  for (int i = 0; i < 32; i++) x[i] = '0;
  for (int i = 0; i < RAM_WORDS; i++) mem[i] = fill_word(i);
  for (int pc = 0; pc < ROM_WORDS; pc++) begin
    w   = prog[pc];
    a   = x[w[19:15]];
    b   = x[w[24:20]];
    val = '0;
    case (w[6:0])
      OPC_OP:     val = isa_alu(w[14:12], w[30], a, b);
      OPC_OP_IMM: val = isa_alu(w[14:12], w[30] && w[14:12] == 3'd5, a,
                                {{20{w[31]}}, w[31:20]});
      OPC_LUI:    val = {w[31:12], 12'd0};
      OPC_AUIPC:  val = 32'(pc * 4) + {w[31:12], 12'd0};
      OPC_LOAD: begin
        addr = a + {{20{w[31]}}, w[31:20]};
        word = mem[addr[7:2]] >> {addr[1:0], 3'b000};
        case (w[13:12])
          2'd0: val = {{24{word[7] & ~w[14]}}, word[7:0]};
          2'd1: val = {{16{word[15] & ~w[14]}}, word[15:0]};
          default: val = word;
        endcase
      end
      default: begin
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        case (w[13:12])
          2'd0: strb = 4'b0001 << addr[1:0];
          2'd1: strb = 4'b0011 << addr[1:0];
          default: strb = 4'b1111;
        endcase
        val = b << {addr[1:0], 3'b000};
        for (int k = 0; k < 4; k++) begin
          if (strb[k]) mem[addr[7:2]][8*k +: 8] = val[8*k +: 8];
        end
        st.addr = {addr[31:2], 2'b00};
        st.data = val;
        st.strb = strb;
        exp_st.push_back(st);
      end
    endcase
    if (w[6:0] != OPC_STORE && w[11:7] != 5'd0) begin
      x[w[11:7]] = val;
      ret.rd     = w[11:7];
      ret.data   = val;
      exp_ret.push_back(ret);
    end
  end
endtask

`endif

// File: testbench/core_tb.sv
`timescale 1ns/1ps

module core_tb
  import core_pkg::*;
();

  localparam int ROM_WORDS      = 64;
  localparam int RAM_WORDS      = 64;
  localparam int NUM_TESTS      = 8;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (ROM_WORDS + 8) * 3;
  localparam logic [31:0] NOP   = 32'h0000_0013; // ADDI x0, x0, 0.

  localparam int KIND_ALU       = 0;
  localparam int KIND_MEM       = 1;
  localparam int KIND_LOAD_USE  = 2;

  `include "core_model.svh"

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic [3:0]  dmem_wstrb;
  logic        dmem_we;
  logic        dmem_stall;
  logic        wb_valid;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic [31:0] ram [RAM_WORDS];
  int          ret_idx = 0;
  int          st_idx = 0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  string       names [5] = '{"alu", "load/store", "load-use", "mixed", "mixed with stalls"};

  rv_core rv_core_i (
    .clk          (clk),
    .reset_i      (reset),
    .imem_addr_o  (imem_addr),
    .imem_data_i  (imem_data),
    .dmem_addr_o  (dmem_addr),
    .dmem_wdata_o (dmem_wdata),
    .dmem_wstrb_o (dmem_wstrb),
    .dmem_we_o    (dmem_we),
    .dmem_rdata_i (dmem_rdata),
    .dmem_stall_i (dmem_stall),
    .wb_valid_o   (wb_valid),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data)
  );

  // Both memories answer combinationally.
  assign imem_data  = (imem_addr[31:8] == 24'd0) ? prog[imem_addr[7:2]] : NOP;
  assign dmem_rdata = ram[dmem_addr[7:2]];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    logic [31:0] m;
    for (int k = 0; k < 4; k++) m[8*k +: 8] = {8{strb[k]}};
    return m;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Retirements and committed stores, in order.
  always @(posedge clk) begin
    logic [31:0] mask;
    logic [31:0] word;
    if (!reset && wb_valid) begin
      assert (ret_idx < exp_ret.size()) else begin
        $display("Retirement of x%0d at %0t was not expected by the model", wb_addr, $time);
        errors++;
      end
      if (ret_idx < exp_ret.size()) begin
        check_value("wb_addr_o", {27'd0, wb_addr}, {27'd0, exp_ret[ret_idx].rd});
        check_value("wb_data_o", wb_data, exp_ret[ret_idx].data);
      end
      ret_idx++;
    end
    if (!reset && dmem_we && !dmem_stall) begin
      assert (st_idx < exp_st.size()) else begin
        $display("Store to %h at %0t was not expected by the model", dmem_addr, $time);
        errors++;
      end
      if (st_idx < exp_st.size()) begin
        mask = lane_mask(exp_st[st_idx].strb);
        check_value("dmem_addr_o", dmem_addr, exp_st[st_idx].addr);
        check_value("dmem_wstrb_o", {28'd0, dmem_wstrb}, {28'd0, exp_st[st_idx].strb});
        check_value("dmem_wdata_o", dmem_wdata & mask, exp_st[st_idx].data & mask);
      end
      word = ram[dmem_addr[7:2]];
      for (int k = 0; k < 4; k++) begin
        if (dmem_wstrb[k]) word[8*k +: 8] = dmem_wdata[8*k +: 8];
      end
      ram[dmem_addr[7:2]] <= word;
      st_idx++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the core stopped retiring", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic run_test(input int num, input string name, input logic stall_en);
    int err_before;
    err_before = errors;
    run_model();
    ret_idx = 0;
    st_idx  = 0;
    @(posedge clk);
    reset      <= 1'b1;
    dmem_stall <= 1'b0;
    repeat (3) @(posedge clk);
    for (int i = 0; i < RAM_WORDS; i++) ram[i] = fill_word(i); // Core is in reset here.
    reset <= 1'b0;
    @(posedge clk);
    check_value("imem_addr_o", imem_addr, 32'd0); // Still idle after reset.
    check_value("wb_valid_o", {31'd0, wb_valid}, 32'd0);
    check_value("dmem_we_o", {31'd0, dmem_we}, 32'd0);
    while (ret_idx < exp_ret.size() || st_idx < exp_st.size()) begin
      @(posedge clk);
      dmem_stall <= stall_en && (rand_bits(8) < 32'd85); // About one cycle in three.
    end
    repeat (8) begin // Pipeline empties, nothing more may retire or store.
      @(posedge clk);
      dmem_stall <= stall_en && (rand_bits(8) < 32'd85);
    end
    dmem_stall <= 1'b0;
    $display("Test %0d %s: %0d retirements, %0d stores, %0d errors", num, name,
             exp_ret.size(), exp_st.size(), errors - err_before);
  endtask

  initial begin
    int name_idx;
    reset      = 1'b1;
    dmem_stall = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      name_idx = (t == NUM_TESTS - 1) ? 4 : t / 2;
      if (t != NUM_TESTS - 1) build_program(t / 2); // Last run repeats the mixed program.
      run_test(t, names[name_idx], t == NUM_TESTS - 1);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+testbench
src/core_pkg.sv
src/pipe_reg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/rv_core.sv
testbench/core_tb.sv
